/* source/exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// one machine word
`define XLEN 32

// destination register index width
`define REG_ADDR_W 5

// data memory depth in words, index wraps at this size
`define DMEM_WORDS 256

`endif

/* source/exe_pkg.sv */
`include "exe_macros.svh"

package exe_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;
    typedef logic [1:0]             pcSel_t;    // carried through, not decoded here

    typedef enum logic [3:0]
    {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } aluFn_t;

    // NONE must stay zero so a reset pipe does nothing
    typedef enum logic [3:0]
    {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } memOp_t;

    // same order as the RV32M funct3 field
    typedef enum logic [2:0]
    {
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
    } mOp_t;

endpackage

/* source/exe_ifs.sv */
interface memReqIf;
    import exe_pkg::*;

    memOp_t memOp;
    word_t  base;       // rs1 value
    word_t  offsetI;    // load offset
    word_t  offsetS;    // store offset
    word_t  storeData;

    modport master
    (
        output memOp, base, offsetI, offsetS, storeData
    );

    modport slave
    (
        input memOp, base, offsetI, offsetS, storeData
    );
endinterface

interface branchIf;
    import exe_pkg::*;

    word_t pc;
    word_t operandA;
    word_t bImm;
    word_t jImm;
    word_t iImm;
    logic  btaken;      // from the alu compare
    logic  j;
    logic  jr;

    modport master
    (
        output pc, operandA, bImm, jImm, iImm, j, jr,
        input  btaken
    );

    modport slave
    (
        input pc, operandA, bImm, jImm, iImm, btaken, j, jr
    );
endinterface

/* source/alu.sv */
module alu
(
    input  exe_pkg::aluFn_t aluFn,
    input  exe_pkg::word_t  operandA,
    input  exe_pkg::word_t  operandB,
    input  logic            bneq,
    input  logic            btype,
    output exe_pkg::word_t  result,
    output logic            btaken
);
    import exe_pkg::*;

    logic [4:0] shamt;
    logic       cond;

    assign shamt = operandB[4:0];   // RV32 masks shift amount

    always_comb
    begin
        case (aluFn)
            ADD:     result = operandA + operandB;
            SUB:     result = operandA - operandB;
            SLL:     result = operandA << shamt;
            SLT:     result = word_t'($signed(operandA) < $signed(operandB));
            SLTU:    result = word_t'(operandA < operandB);
            XOR:     result = operandA ^ operandB;
            SRL:     result = operandA >> shamt;
            SRA:     result = word_t'($signed(operandA) >>> shamt);
            OR:      result = operandA | operandB;
            AND:     result = operandA & operandB;
            default: result = '0;
        endcase
    end

    // compare outcome reused for conditional branches
    always_comb
    begin
        case (aluFn)
            SUB:       cond = (result == '0);   // beq / bne
            SLT, SLTU: cond = result[0];        // blt(u) / bge(u)
            default:   cond = 1'b0;
        endcase
    end

    assign btaken = btype & (cond ^ bneq);

endmodule

/* source/branch_unit.sv */
module branch_unit
(
    branchIf.slave         br,
    output exe_pkg::word_t target
);
    import exe_pkg::*;

    word_t jrSum;

    assign jrSum = br.operandA + br.iImm;

    // jalr wins over jal, then taken branches
    always_comb
    begin
        if (br.jr)
        begin
            target = {jrSum[$bits(word_t)-1:1], 1'b0};
        end
        else if (br.j)
        begin
            target = br.pc + br.jImm;
        end
        else if (br.btaken)
        begin
            target = br.pc + br.bImm;
        end
        else
        begin
            target = br.pc + word_t'(4);    // fall through
        end
    end

endmodule

/* source/mul_div.sv */
module mul_div
(
    input  exe_pkg::word_t a,
    input  exe_pkg::word_t b,
    input  exe_pkg::mOp_t  mOp,
    output exe_pkg::word_t res
);
    import exe_pkg::*;

    localparam int W = $bits(word_t);

    logic               aSigned, bSigned;
    logic signed [W:0]  aExt, bExt;
    logic signed [2*W+1:0] prod;
    logic               divZero, divOvf;
    logic signed [W-1:0] quotS, remS;
    word_t              quotU, remU;

    // one signed multiplier covers all four products
    assign aSigned = (mOp == MULH) || (mOp == MULHSU);
    assign bSigned = (mOp == MULH);
    assign aExt    = {aSigned & a[W-1], a};
    assign bExt    = {bSigned & b[W-1], b};
    assign prod    = aExt * bExt;

    assign divZero = (b == '0);
    assign divOvf  = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);   // min / -1

    assign quotS = $signed(a) / $signed(b);
    assign remS  = $signed(a) % $signed(b);   // sign follows dividend
    assign quotU = a / b;
    assign remU  = a % b;

    always_comb
    begin
        case (mOp)
            MUL:                  res = prod[W-1:0];
            MULH, MULHSU, MULHU:  res = prod[2*W-1:W];
            DIV:     res = divZero ? '1 : (divOvf ? a : word_t'(quotS));
            DIVU:    res = divZero ? '1 : quotU;
            REM:     res = divZero ? a : (divOvf ? '0 : word_t'(remS));
            REMU:    res = divZero ? a : remU;
            default: res = '0;
        endcase
    end

endmodule

/* source/dmem_access.sv */
`include "exe_macros.svh"

module dmem_access
(
    input  logic           clk,
    input  logic           nrst,
    memReqIf.slave         req,
    output exe_pkg::word_t memOut,
    output logic           addrMisaligned
);
    import exe_pkg::*;

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    word_t            mem [`DMEM_WORDS];
    memOp_t           opReg;
    word_t            addrReg, dataReg;
    word_t            effAddr;
    logic             reqStore, isLoad, misaligned;
    logic [1:0]       byteOff;
    logic [IDX_W-1:0] wordIdx;
    logic [3:0]       wrMask;
    word_t            wrData, rdShift, loadVal;

    assign reqStore = req.memOp inside {SB, SH, SW};
    assign effAddr  = req.base + (reqStore ? req.offsetS : req.offsetI);

    assign byteOff = addrReg[1:0];
    assign wordIdx = addrReg[IDX_W+1:2];    // wraps over memory depth
    assign isLoad  = opReg inside {LB, LH, LW, LBU, LHU};

    always_comb
    begin
        misaligned = 1'b0;
        wrMask     = 4'b0000;
        wrData     = dataReg;
        loadVal    = '0;
        rdShift    = mem[wordIdx] >> {byteOff, 3'b000};
        case (opReg)
            LH, LHU, SH: misaligned = byteOff[0];
            LW, SW:      misaligned = (byteOff != 2'b00);
            default:     misaligned = 1'b0;
        endcase
        case (opReg)
            SB:      wrMask = 4'b0001 << byteOff;
            SH:      wrMask = 4'b0011 << byteOff;
            SW:      wrMask = 4'b1111;
            default: wrMask = 4'b0000;
        endcase
        case (opReg)
            SB:      wrData = {4{dataReg[7:0]}};    // replicate to every lane
            SH:      wrData = {2{dataReg[15:0]}};
            LB:      loadVal = {{24{rdShift[7]}}, rdShift[7:0]};
            LH:      loadVal = {{16{rdShift[15]}}, rdShift[15:0]};
            LW:      loadVal = rdShift;
            LBU:     loadVal = {24'b0, rdShift[7:0]};
            LHU:     loadVal = {16'b0, rdShift[15:0]};
            default: loadVal = '0;
        endcase
        if (misaligned)
        begin
            wrMask  = 4'b0000;      // bad store is dropped
            loadVal = '0;
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            opReg          <= NONE;
            addrReg        <= '0;
            dataReg        <= '0;
            memOut         <= '0;
            addrMisaligned <= 1'b0;
        end
        else
        begin
            opReg          <= req.memOp;
            addrReg        <= effAddr;
            dataReg        <= req.storeData;
            addrMisaligned <= misaligned;
            if (isLoad)
                memOut <= loadVal;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (wrMask[i])
                mem[wordIdx][i*8 +: 8] <= wrData[i*8 +: 8];
        end
    end

endmodule

/* source/exe_stage.sv */
module exe_stage
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              we4, bneq4, btype4, j4, jr4,
    input  logic [2:0]        fn4,
    input  exe_pkg::regAddr_t rd4,
    input  exe_pkg::aluFn_t   alu_fn4,
    input  exe_pkg::word_t    op_a, op_b,
    input  exe_pkg::word_t    pc4, B_imm4, J_imm4, S_imm4,
    input  exe_pkg::pcSel_t   pcselect4,
    input  exe_pkg::memOp_t   mem_op4,
    input  exe_pkg::mOp_t     m_op4,
    output logic              we5, j5, jr5,
    output logic [2:0]        fn5,
    output exe_pkg::regAddr_t rd5,
    output exe_pkg::pcSel_t   pcselect5,
    output exe_pkg::word_t    alu_res5, target, mul_div5, mem_out6,
    output logic              addr_misaligned6
);
    import exe_pkg::*;

    logic     weReg, bneqReg, btypeReg, jReg, jrReg;
    logic [2:0] fnReg;
    regAddr_t rdReg;
    aluFn_t   aluFnReg;
    word_t    opAReg, opBReg;     // pipe 5 operands
    word_t    pcReg, bImmReg, jImmReg;
    pcSel_t   pcSelReg;
    mOp_t     mOpReg;

    memReqIf memReq();
    branchIf brBus();

    // memory path registers its own copy of stage 4
    assign memReq.memOp     = mem_op4;
    assign memReq.base      = op_a;
    assign memReq.offsetI   = op_b;
    assign memReq.offsetS   = S_imm4;
    assign memReq.storeData = op_b;     // rs2 for stores

    assign brBus.pc       = pcReg;
    assign brBus.operandA = opAReg;
    assign brBus.bImm     = bImmReg;
    assign brBus.jImm     = jImmReg;
    assign brBus.iImm     = opBReg;     // I immediate rides on operand B
    assign brBus.j        = jReg;
    assign brBus.jr       = jrReg;

    alu exeAlu
    (
        .aluFn    (aluFnReg),
        .operandA (opAReg),
        .operandB (opBReg),
        .bneq     (bneqReg),
        .btype    (btypeReg),
        .result   (alu_res5),
        .btaken   (brBus.btaken)
    );

    branch_unit exeBu
    (
        .br     (brBus.slave),
        .target (target)
    );

    mul_div exeMulDiv
    (
        .a   (opAReg),
        .b   (opBReg),
        .mOp (mOpReg),
        .res (mul_div5)
    );

    dmem_access exeDmem
    (
        .clk            (clk),
        .nrst           (nrst),
        .req            (memReq.slave),
        .memOut         (mem_out6),
        .addrMisaligned (addr_misaligned6)
    );

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            weReg    <= 1'b0;
            bneqReg  <= 1'b0;
            btypeReg <= 1'b0;
            jReg     <= 1'b0;
            jrReg    <= 1'b0;
            fnReg    <= '0;
            rdReg    <= '0;
            aluFnReg <= ADD;
            opAReg   <= '0;
            opBReg   <= '0;
            pcReg    <= '0;
            bImmReg  <= '0;
            jImmReg  <= '0;
            pcSelReg <= '0;
            mOpReg   <= MUL;
        end
        else
        begin
            weReg    <= we4;
            bneqReg  <= bneq4;
            btypeReg <= btype4;
            jReg     <= j4;
            jrReg    <= jr4;
            fnReg    <= fn4;
            rdReg    <= rd4;
            aluFnReg <= alu_fn4;
            opAReg   <= op_a;
            opBReg   <= op_b;
            pcReg    <= pc4;
            bImmReg  <= B_imm4;
            jImmReg  <= J_imm4;
            pcSelReg <= pcselect4;
            mOpReg   <= m_op4;
        end
    end

    // carried control goes straight to writeback
    assign we5       = weReg;
    assign j5        = jReg;
    assign jr5       = jrReg;
    assign fn5       = fnReg;
    assign rd5       = rdReg;
    assign pcselect5 = pcSelReg;

endmodule

/* sim/exe_stage_assertions.sv */
module exe_stage_assertions
(
    input logic              clk,
    input logic              nrst,
    input logic              we5, j5, jr5,
    input exe_pkg::regAddr_t rd4, rd5,
    input exe_pkg::memOp_t   mem_op4,
    input logic              addr_misaligned6
);
    import exe_pkg::*;

    int failCount = 0;  // read by the testbench every cycle

    // carried control stays quiet in reset
    resetQuiet: assert property (@(posedge clk) !nrst |-> !(we5 || j5 || jr5))
    else
    begin
        failCount++;
        $error("we5, j5 or jr5 active while nrst is low");
    end

    rdFollows: assert property (@(posedge clk) disable iff (!nrst)
        $past(nrst) |-> rd5 == $past(rd4))
    else
    begin
        failCount++;
        $error("rd5 does not follow rd4 of the previous cycle");
    end

    // two cycles from request to flag
    noneAligned: assert property (@(posedge clk) disable iff (!nrst)
        $past(mem_op4 == NONE, 2) |-> !addr_misaligned6)
    else
    begin
        failCount++;
        $error("addr_misaligned6 set after a NONE memory op");
    end
endmodule

bind exe_stage exe_stage_assertions exeStageChecks
(
    .clk              (clk),
    .nrst             (nrst),
    .we5              (we5),
    .j5               (j5),
    .jr5              (jr5),
    .rd4              (rd4),
    .rd5              (rd5),
    .mem_op4          (mem_op4),
    .addr_misaligned6 (addr_misaligned6)
);

/* sim/exe_stage_tb.sv */
`include "exe_macros.svh"

module exe_stage_tb;
    import exe_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_OPS      = 2000;

    typedef struct packed
    {
        logic       we, bneq, btype, j, jr;
        logic [2:0] fn;
        regAddr_t   rd;
        aluFn_t     aluFn;
        word_t      a, b, pc, bImm, jImm, sImm;
        pcSel_t     pcSel;
        memOp_t     memOp;
        mOp_t       mOp;
    } opIn_t;

    typedef struct
    {
        logic       we, j, jr;
        logic [2:0] fn;
        regAddr_t   rd;
        pcSel_t     pcSel;
        word_t      alu, target, md;
    } pipeExp_t;

    typedef struct
    {
        logic  isLoad;
        logic  mis;
        word_t loadVal;
    } memExp_t;

    logic       clk = 1'b0;
    logic       nrst;
    logic       we4, bneq4, btype4, j4, jr4;
    logic [2:0] fn4;
    regAddr_t   rd4;
    aluFn_t     alu_fn4;
    word_t      op_a, op_b, pc4, B_imm4, J_imm4, S_imm4;
    pcSel_t     pcselect4;
    memOp_t     mem_op4;
    mOp_t       m_op4;
    logic       we5, j5, jr5;
    logic [2:0] fn5;
    regAddr_t   rd5;
    pcSel_t     pcselect5;
    word_t      alu_res5, target, mul_div5, mem_out6;
    logic       addr_misaligned6;

    integer   seed = 32'h5672a46d;
    word_t    modelMem [int];   // words written whole at least once
    pipeExp_t pipeQ [$];
    memExp_t  memQ [$];         // two ops deep once running
    word_t    expMemOut;        // holds between loads

    exe_stage exe_stage_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkReg(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkPcSel(input string name, input pcSel_t got, input pcSel_t exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkFn(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic checkAssertions();
        if (exe_stage_inst.exeStageChecks.failCount != 0)
            abortRun("a bound assertion on exe_stage failed");
    endtask

    function automatic int memSize(input memOp_t op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic isStore(input memOp_t op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic logic isLoadOp(input memOp_t op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic int wordIndex(input word_t addr);
        return int'((addr >> 2) % `DMEM_WORDS);
    endfunction

    function automatic word_t aluModel(input aluFn_t fn, input word_t a, input word_t b);
        case (fn)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SRA:     return word_t'($signed(a) >>> b[4:0]);
            OR:      return a | b;
            AND:     return a & b;
            default: return '0;
        endcase
    endfunction

    // beq/bne on SUB, blt(u)/bge(u) on SLT(U)
    function automatic logic branchTaken(input aluFn_t fn, input word_t res, input logic btype,
                                         input logic bneq);
        logic cond;
        cond = ((fn == SUB) && (res == '0)) || ((fn inside {SLT, SLTU}) && (res == 32'd1));
        return btype && (cond != bneq);
    endfunction

    function automatic word_t mulDivModel(input mOp_t op, input word_t a, input word_t b);
        longint      prod;
        logic [63:0] uprod;
        case (op)
            MUL:
                return a * b;
            MULH:
            begin
                prod = longint'($signed(a)) * longint'($signed(b));
                return prod[63:32];
            end
            MULHSU:
            begin
                prod = longint'($signed(a)) * longint'({32'b0, b});
                return prod[63:32];
            end
            MULHU:
            begin
                uprod = {32'b0, a} * {32'b0, b};
                return uprod[63:32];
            end
            DIV:
            begin
                if (b == '0)
                    return '1;
                if (a == 32'h8000_0000 && b == '1)
                    return a;   // signed overflow
                return word_t'(int'(a) / int'(b));
            end
            DIVU:
            begin
                if (b == '0)
                    return '1;
                return a / b;
            end
            REM:
            begin
                if (b == '0)
                    return a;
                if (a == 32'h8000_0000 && b == '1)
                    return '0;
                return word_t'(int'(a) % int'(b));
            end
            default:
            begin
                if (b == '0)
                    return a;
                return a % b;
            end
        endcase
    endfunction

    task automatic genOp(output opIn_t o);
        logic [31:0] r;
        word_t       addr, off;
        int          sz;

        r = $random(seed);
        o.we    = r[0];
        o.bneq  = r[1];
        o.btype = r[2];
        o.j     = r[3] & r[4];
        o.jr    = r[5] & r[6];
        o.fn    = r[9:7];
        o.rd    = r[14:10];
        o.pcSel = r[16:15];
        o.mOp   = mOp_t'(r[19:17]);
        o.aluFn = aluFn_t'(4'(r[27:20] % 10));
        o.a     = $random(seed);
        o.b     = $random(seed);
        o.pc    = $random(seed) & 32'hffff_fffc;
        o.bImm  = $random(seed) & 32'hffff_fffe;
        o.jImm  = $random(seed) & 32'hffff_fffe;
        o.sImm  = $random(seed);
        r = $random(seed);
        o.memOp = r[0] ? memOp_t'(4'(1 + r[3:1])) : NONE;
        if (o.memOp == NONE)
        begin
            case (r[7:4])   // corner operands for divide and compare
                4'd0:
                    o.b = '0;
                4'd1:
                begin
                    o.a = 32'h8000_0000;
                    o.b = '1;
                end
                4'd2:
                    o.b = o.a;
                default:
                    o.b = o.b;
            endcase
        end
        else
        begin
            sz   = memSize(o.memOp);
            addr = 32'h80 + word_t'(r[13:8]);   // 64-byte window
            if (r[15:14] != 2'b00)
                addr = addr & ~word_t'(sz - 1);
            if (isLoadOp(o.memOp) && !modelMem.exists(wordIndex(addr)))
            begin
                o.memOp = SW;   // fill the word before reading it
                addr    = addr & ~word_t'(3);
            end
            off = {{26{r[21]}}, r[21:16]};
            o.a = addr - off;
            if (isStore(o.memOp))
                o.sImm = off;
            else
                o.b = off;
        end
    endtask

    task automatic applyOp(input opIn_t o);
        we4       <= o.we;
        bneq4     <= o.bneq;
        btype4    <= o.btype;
        j4        <= o.j;
        jr4       <= o.jr;
        fn4       <= o.fn;
        rd4       <= o.rd;
        alu_fn4   <= o.aluFn;
        op_a      <= o.a;
        op_b      <= o.b;
        pc4       <= o.pc;
        B_imm4    <= o.bImm;
        J_imm4    <= o.jImm;
        S_imm4    <= o.sImm;
        pcselect4 <= o.pcSel;
        mem_op4   <= o.memOp;
        m_op4     <= o.mOp;
    endtask

    task automatic modelOp(input opIn_t o);
        pipeExp_t p;
        memExp_t  m;
        word_t    addr, w;
        int       sz, off, idx, i;
        logic     taken;

        p.we    = o.we;
        p.j     = o.j;
        p.jr    = o.jr;
        p.fn    = o.fn;
        p.rd    = o.rd;
        p.pcSel = o.pcSel;
        p.alu   = aluModel(o.aluFn, o.a, o.b);
        taken   = branchTaken(o.aluFn, p.alu, o.btype, o.bneq);
        if (o.jr)
            p.target = (o.a + o.b) & ~word_t'(1);
        else if (o.j)
            p.target = o.pc + o.jImm;
        else if (taken)
            p.target = o.pc + o.bImm;
        else
            p.target = o.pc + 32'd4;
        p.md = mulDivModel(o.mOp, o.a, o.b);
        pipeQ.push_back(p);

        m.isLoad  = isLoadOp(o.memOp);
        m.mis     = 1'b0;
        m.loadVal = '0;
        if (o.memOp != NONE)
        begin
            addr  = o.a + (isStore(o.memOp) ? o.sImm : o.b);
            sz    = memSize(o.memOp);
            off   = int'(addr[1:0]);
            idx   = wordIndex(addr);
            m.mis = (off % sz) != 0;
            if (!m.mis && o.memOp == SW)
                modelMem[idx] = o.b;
            else if (!m.mis && isStore(o.memOp) && modelMem.exists(idx))
            begin
                w = modelMem[idx];
                for (i = 0; i < sz; i++)
                    w[8*(off+i) +: 8] = o.b[8*i +: 8];  // lanes from the low address bits
                modelMem[idx] = w;
            end
            if (m.isLoad && !m.mis)
            begin
                w = modelMem[idx] >> (8 * off);
                case (o.memOp)
                    LB:      m.loadVal = {{24{w[7]}}, w[7:0]};
                    LH:      m.loadVal = {{16{w[15]}}, w[15:0]};
                    LBU:     m.loadVal = {24'b0, w[7:0]};
                    LHU:     m.loadVal = {16'b0, w[15:0]};
                    default: m.loadVal = w;
                endcase
            end
        end
        memQ.push_back(m);
    endtask

    task automatic checkResetState();
        checkBit("we5", we5, 1'b0);
        checkBit("j5", j5, 1'b0);
        checkBit("jr5", jr5, 1'b0);
        checkPcSel("pcselect5", pcselect5, '0);
        checkBit("addr_misaligned6", addr_misaligned6, 1'b0);
        checkWord("mem_out6", mem_out6, '0);
    endtask

    initial
    begin
        #((RESET_CYCLES + NUM_OPS + 10) * CLK_PERIOD);
        abortRun("timeout, the run did not finish in time");
    end

    initial
    begin
        opIn_t    o;
        pipeExp_t p;
        memExp_t  m;
        int       k;

        nrst <= 1'b0;
        o = '0;
        o.we    = 1'b1;     // live control held off by reset
        o.j     = 1'b1;
        o.jr    = 1'b1;
        o.pcSel = 2'b11;
        o.memOp = LW;
        o.a     = 32'h81;   // misaligned word load
        applyOp(o);
        expMemOut = '0;
        m.isLoad  = 1'b0;
        m.mis     = 1'b0;
        m.loadVal = '0;
        memQ.push_back(m);  // reset contents of dmem pipe
        o = '0;
        modelOp(o);
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            checkResetState();
        end
        @(posedge clk);
        nrst <= 1'b1;
        applyOp(o);         // idle op first after release

        for (k = 0; k < NUM_OPS; k++)
        begin
            @(posedge clk);
            genOp(o);
            applyOp(o);
            modelOp(o);
            @(negedge clk);
            p = pipeQ.pop_front();  // op of one cycle ago
            checkBit("we5", we5, p.we);
            checkBit("j5", j5, p.j);
            checkBit("jr5", jr5, p.jr);
            checkFn("fn5", fn5, p.fn);
            checkReg("rd5", rd5, p.rd);
            checkPcSel("pcselect5", pcselect5, p.pcSel);
            checkWord("alu_res5", alu_res5, p.alu);
            checkWord("target", target, p.target);
            checkWord("mul_div5", mul_div5, p.md);
            m = memQ.pop_front();   // op of two cycles ago
            if (m.isLoad)
                expMemOut = m.loadVal;
            checkWord("mem_out6", mem_out6, expMemOut);
            checkBit("addr_misaligned6", addr_misaligned6, m.mis);
            checkAssertions();
        end

        $display("all tests passed");
        $finish;
    end
endmodule

/* list.f */
+incdir+source
source/exe_pkg.sv
source/exe_ifs.sv
source/alu.sv
source/branch_unit.sv
source/mul_div.sv
source/dmem_access.sv
source/exe_stage.sv
sim/exe_stage_assertions.sv
sim/exe_stage_tb.sv
